// ==== noc_router_pkg.sv ====
`default_nettype none

package noc_router_pkg;

    localparam int PORT_W    = 3;   // up to 8 ports
    localparam int PAYLOAD_W = 32;

    typedef logic [PORT_W-1:0] port_idx_t;

    // flit opcode
    typedef enum logic [1:0] {
        FLIT_BODY   = 2'b00,
        FLIT_HEAD   = 2'b01,
        FLIT_TAIL   = 2'b10,
        FLIT_SINGLE = 2'b11
    } flit_kind_e;

    typedef struct packed {
        flit_kind_e           kind;
        port_idx_t            dest;     // only meaningful in head or single
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // one link direction
    typedef struct packed {
        logic  flit_wr;
        flit_t flit;
        logic  credit;    // slot freed at the far end
    } chan_t;

    // input port request towards the allocator
    typedef struct packed {
        logic      valid;
        port_idx_t dest;
        logic      last;      // flit closes its packet
    } sa_req_t;

    typedef enum logic {
        IP_IDLE   = 1'b0,     // expecting an opening flit
        IP_ACTIVE = 1'b1      // route latched
    } ip_state_e;

    // head or single
    function automatic logic flit_opens(input flit_kind_e kind);
        return (kind == FLIT_HEAD) || (kind == FLIT_SINGLE);
    endfunction

    // tail or single
    function automatic logic flit_closes(input flit_kind_e kind);
        return (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
    endfunction

endpackage

`default_nettype wire

// ==== input_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_port #(
    parameter int P         = 5,
    parameter int BUF_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  noc_router_pkg::chan_t   chan_rx,
    input  logic                    grant,
    output noc_router_pkg::sa_req_t req,
    output noc_router_pkg::flit_t   head_flit,
    output logic                    credit
);
    import noc_router_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    // dest field has to reach every output
    if (P > (1 << PORT_W)) begin : g_port_range
        $error("input_port: P=%0d does not fit in the port index", P);
    end

    flit_t            mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    ip_state_e        state;
    port_idx_t        dest_q;     // route of the packet in flight
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = chan_rx.flit_wr;     // upstream only sends with credit
    assign pop  = grant && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= chan_rx.flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // wormhole route tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IP_IDLE;
        end else if (pop) begin
            if (flit_closes(head_flit.kind)) begin
                state <= IP_IDLE;
            end else if (flit_opens(head_flit.kind)) begin
                state <= IP_ACTIVE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && state == IP_IDLE) begin
            dest_q <= head_flit.dest;
        end
    end

    // one credit per freed slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

    assign head_flit = mem[rd_ptr];

    always_comb begin
        req.valid = (count != '0);
        req.dest  = (state == IP_IDLE) ? head_flit.dest : dest_q;  // body reuses latched route
        req.last  = flit_closes(head_flit.kind);
    end

endmodule

`default_nettype wire

// ==== switch_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator #(
    parameter int P         = 5,
    parameter int BUF_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  noc_router_pkg::sa_req_t   req [P],
    input  logic [P-1:0]              credit_in,
    output logic [P-1:0]              in_grant,
    output logic [P-1:0]              out_valid,
    output noc_router_pkg::port_idx_t out_sel [P]
);
    import noc_router_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [P-1:0]     cand       [P];   // per output, eligible inputs
    logic [P-1:0]     gnt_mat    [P];   // per output, one-hot winner
    logic [P-1:0]     lock_vld;
    port_idx_t        lock_owner [P];
    port_idx_t        rr_ptr     [P];   // highest priority input
    logic [CNT_W-1:0] credit_cnt [P];   // free slots downstream
    logic [P-1:0]     out_last;         // winner closes its packet

    // request matrix, a locked output only sees its owner
    always_comb begin
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                cand[o][i] = req[i].valid
                             && (req[i].dest == port_idx_t'(o))
                             && (!lock_vld[o] || lock_owner[o] == port_idx_t'(i));
            end
        end
    end

    // round-robin per output, starting at rr_ptr
    always_comb begin
        int idx;
        for (int o = 0; o < P; o++) begin
            gnt_mat[o]   = '0;
            out_valid[o] = 1'b0;
            out_sel[o]   = '0;
            out_last[o]  = 1'b0;
            for (int k = 0; k < P; k++) begin
                idx = (int'(rr_ptr[o]) + k) % P;
                if (!out_valid[o] && cand[o][idx] && credit_cnt[o] != '0) begin
                    gnt_mat[o][idx] = 1'b1;
                    out_valid[o]    = 1'b1;
                    out_sel[o]      = port_idx_t'(idx);
                    out_last[o]     = req[idx].last;
                end
            end
        end
    end

    // each input names a single output, so at most one bit per input
    always_comb begin
        in_grant = '0;
        for (int o = 0; o < P; o++) begin
            in_grant = in_grant | gnt_mat[o];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_vld <= '0;
            for (int o = 0; o < P; o++) begin
                lock_owner[o] <= '0;
                rr_ptr[o]     <= '0;
                credit_cnt[o] <= CNT_W'(BUF_DEPTH);
            end
        end else begin
            for (int o = 0; o < P; o++) begin
                credit_cnt[o] <= credit_cnt[o] + CNT_W'(credit_in[o]) - CNT_W'(out_valid[o]);
                if (out_valid[o]) begin
                    lock_vld[o]   <= !out_last[o];  // tail frees the output
                    lock_owner[o] <= out_sel[o];
                    // next search starts just after the winner
                    rr_ptr[o] <= (out_sel[o] == port_idx_t'(P - 1)) ? '0 : out_sel[o] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== crossbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module crossbar #(
    parameter int P = 5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  noc_router_pkg::flit_t     head_flit [P],
    input  logic [P-1:0]              out_valid,
    input  noc_router_pkg::port_idx_t out_sel   [P],
    output noc_router_pkg::flit_t     flit_out  [P],
    output logic [P-1:0]              flit_wr
);

    // link register, strobe side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flit_wr <= '0;
        end else begin
            flit_wr <= out_valid;
        end
    end

    // flit data only moves on a grant
    for (genvar o = 0; o < P; o++) begin : g_out
        always_ff @(posedge clk) begin
            if (out_valid[o]) begin
                flit_out[o] <= head_flit[out_sel[o]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== credit_release_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_release_gen #(
    parameter int BUF_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    output logic credit_out
);

    localparam int W = $clog2(BUF_DEPTH + 1);

    logic [W-1:0] count;
    logic         count_zero;
    logic         count_max;
    logic         step;

    assign count_zero = (count == '0);
    assign count_max  = (count == W'(BUF_DEPTH));
    assign step       = (en && count_zero) || (!count_zero && !count_max);  // start or keep going

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count      <= '0;
            credit_out <= 1'b0;
        end else begin
            credit_out <= step;
            if (step) begin
                count <= count + 1'b1;
            end else if (count_max) begin
                count <= '0;   // burst done, rearm
            end
        end
    end

endmodule

`default_nettype wire

// ==== router_two_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_two_stage #(
    parameter int P         = 5,
    parameter int BUF_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  noc_router_pkg::chan_t chan_in  [P],
    output noc_router_pkg::chan_t chan_out [P],
    input  logic [P-1:0]          credit_release_en
);
    import noc_router_pkg::*;

    sa_req_t      sa_req    [P];
    flit_t        head_flit [P];
    flit_t        xbar_flit [P];
    port_idx_t    out_sel   [P];
    logic [P-1:0] in_grant;
    logic [P-1:0] out_valid;
    logic [P-1:0] xbar_wr;
    logic [P-1:0] ip_credit;    // from freed input slots
    logic [P-1:0] rel_credit;   // endpoint release bursts
    logic [P-1:0] credit_in;    // downstream returns

    for (genvar p = 0; p < P; p++) begin : g_port
        input_port #(
            .P         (P),
            .BUF_DEPTH (BUF_DEPTH)
        ) i_input_port (
            .clk       (clk),
            .rst_n     (rst_n),
            .chan_rx   (chan_in[p]),
            .grant     (in_grant[p]),
            .req       (sa_req[p]),
            .head_flit (head_flit[p]),
            .credit    (ip_credit[p])
        );

        credit_release_gen #(
            .BUF_DEPTH (BUF_DEPTH)
        ) i_credit_release (
            .clk        (clk),
            .rst_n      (rst_n),
            .en         (credit_release_en[p]),
            .credit_out (rel_credit[p])
        );

        assign credit_in[p] = chan_in[p].credit;

        assign chan_out[p] = '{
            flit_wr: xbar_wr[p],
            flit:    xbar_flit[p],
            credit:  ip_credit[p] | rel_credit[p]
        };
    end

    // stage 1
    switch_allocator #(
        .P         (P),
        .BUF_DEPTH (BUF_DEPTH)
    ) i_switch_allocator (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (sa_req),
        .credit_in (credit_in),
        .in_grant  (in_grant),
        .out_valid (out_valid),
        .out_sel   (out_sel)
    );

    // stage 2
    crossbar #(
        .P (P)
    ) i_crossbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_flit (head_flit),
        .out_valid (out_valid),
        .out_sel   (out_sel),
        .flit_out  (xbar_flit),
        .flit_wr   (xbar_wr)
    );

endmodule

`default_nettype wire

// ==== router_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_assertions #(
    parameter int P         = 5,
    parameter int BUF_DEPTH = 4
) (
    input logic                      clk,
    input logic                      rst_n,
    input noc_router_pkg::sa_req_t   req       [P],
    input logic [P-1:0]              credit_in,
    input logic [P-1:0]              in_grant,
    input logic [P-1:0]              out_valid,
    input noc_router_pkg::port_idx_t out_sel   [P]
);
    import noc_router_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    int               assert_fails = 0;   // read by the testbench at the end
    logic [P-1:0]     to_out [P];         // inputs whose request names output o
    logic [CNT_W-1:0] slots  [P];         // downstream room from the credit rule

    always_comb begin
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                to_out[o][i] = req[i].valid && (req[i].dest == port_idx_t'(o));
            end
        end
    end

    // starts full, up on a returned credit, down on a grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < P; o++) begin
                slots[o] <= CNT_W'(BUF_DEPTH);
            end
        end else begin
            for (int o = 0; o < P; o++) begin
                case ({credit_in[o], out_valid[o]})
                    2'b10:   slots[o] <= slots[o] + 1'b1;
                    2'b01:   slots[o] <= slots[o] - 1'b1;
                    default: slots[o] <= slots[o];
                endcase
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out
        a_one_winner: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(in_grant & to_out[o]))
        else begin
            $error("output %0d granted more than one input", o);
            assert_fails++;
        end

        // no flit may leave without a downstream slot
        a_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[o] |-> slots[o] != '0)
        else begin
            $error("output %0d granted with zero credits", o);
            assert_fails++;
        end

        a_sel_granted: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[o] |-> in_grant[out_sel[o]] && to_out[o][out_sel[o]])
        else begin
            $error("output %0d selects an input without a grant", o);
            assert_fails++;
        end
    end

endmodule

bind switch_allocator router_assertions #(
    .P         (P),
    .BUF_DEPTH (BUF_DEPTH)
) i_router_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .credit_in (credit_in),
    .in_grant  (in_grant),
    .out_valid (out_valid),
    .out_sel   (out_sel)
);

`default_nettype wire

// ==== tb_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_router;
    import noc_router_pkg::*;

    localparam int NP              = 5;
    localparam int DEPTH           = 4;
    localparam int WAIT_LIMIT      = 100;   // per wait for output flits
    localparam int WATCHDOG_CYCLES = 3000;  // five tests, each well under 600 cycles

    logic          clk = 1'b0;
    logic          rst_n;
    chan_t         chan_in  [NP];
    chan_t         chan_out [NP];
    logic [NP-1:0] credit_release_en;

    int          cyc          = 0;
    int          err_count    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] lcg_state    = 32'h78949439;

    flit_t tx_q      [NP][$];   // flits waiting for an upstream credit
    flit_t rx_q      [NP][$];   // flits seen on chan_out
    int    rx_edge   [NP][$];
    int    cred_edge [NP][$];   // credit pulses on chan_out
    int    sent_edge [NP];
    int    up_credit [NP];      // upstream sender credit counters
    int    ret_pend  [NP];      // downstream credits still to return
    logic  hold      [NP];      // withhold downstream credits

    router_two_stage #(
        .P         (NP),
        .BUF_DEPTH (DEPTH)
    ) i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .chan_in           (chan_in),
        .chan_out          (chan_out),
        .credit_release_en (credit_release_en)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // upstream senders and downstream credit return
    always @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (!rst_n) begin
                chan_in[p]   <= '0;
                up_credit[p] = DEPTH;
                ret_pend[p]  = 0;
            end else begin
                if (chan_out[p].credit) begin
                    up_credit[p]++;
                end
                if (tx_q[p].size() > 0 && up_credit[p] > 0) begin
                    chan_in[p].flit_wr <= 1'b1;
                    chan_in[p].flit    <= tx_q[p].pop_front();
                    up_credit[p]--;
                    sent_edge[p] = cyc + 1;
                end else begin
                    chan_in[p].flit_wr <= 1'b0;
                end
                if (chan_out[p].flit_wr) begin
                    ret_pend[p]++;
                end
                if (!hold[p] && ret_pend[p] > 0) begin
                    chan_in[p].credit <= 1'b1;   // one cycle after the flit
                    ret_pend[p]--;
                end else begin
                    chan_in[p].credit <= 1'b0;
                end
            end
        end
    end

    // stamps are the edge that registered the output
    always @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (chan_out[p].flit_wr) begin
                rx_q[p].push_back(chan_out[p].flit);
                rx_edge[p].push_back(cyc);
            end
            if (chan_out[p].credit) begin
                cred_edge[p].push_back(cyc);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic string flit_str(input flit_t f);
        return $sformatf("kind=%0d dest=%0d payload=%h", f.kind, f.dest, f.payload);
    endfunction

    task automatic check_flit(input string name, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %s, actual %s", name, flit_str(exp), flit_str(act));
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic clear_monitors();
        for (int p = 0; p < NP; p++) begin
            rx_q[p].delete();
            rx_edge[p].delete();
            cred_edge[p].delete();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        clear_monitors();
    endtask

    // head/body/tail, or one single flit; dest only in the opening flit
    task automatic send_packet(input int src, input int dest, input int len,
                               output flit_t pkt [$]);
        flit_t f;
        pkt.delete();
        for (int i = 0; i < len; i++) begin
            if (len == 1) begin
                f.kind = FLIT_SINGLE;
            end else if (i == 0) begin
                f.kind = FLIT_HEAD;
            end else if (i == len - 1) begin
                f.kind = FLIT_TAIL;
            end else begin
                f.kind = FLIT_BODY;
            end
            f.dest    = (i == 0) ? port_idx_t'(dest) : '0;
            f.payload = lcg_next();
            pkt.push_back(f);
            tx_q[src].push_back(f);
        end
    endtask

    task automatic wait_rx(input string name, input int o, input int n, output bit ok);
        int waited;
        waited = 0;
        while (rx_q[o].size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = (rx_q[o].size() >= n);
        if (!ok) begin
            $display("%s: only %0d of %0d flits arrived on output %0d",
                     name, rx_q[o].size(), n, o);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = err_count;
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            for (int p = 0; p < NP; p++) begin
                check_bit("reset", 1'b0, chan_out[p].flit_wr);
                check_bit("reset", 1'b0, chan_out[p].credit);
            end
        end
        finish_test("reset", errs);
    endtask

    task automatic test_single_flits();
        int    errs;
        int    dest;
        bit    ok;
        flit_t exp [NP][$];
        errs = err_count;
        clear_monitors();
        for (int p = 0; p < NP; p++) begin
            send_packet(p, (p * 3 + 1) % NP, 1, exp[p]);  // permutation, port 2 loops back
        end
        for (int p = 0; p < NP; p++) begin
            dest = (p * 3 + 1) % NP;
            wait_rx("single_flits", dest, 1, ok);
            if (ok) begin
                check_flit("single_flits", exp[p][0], rx_q[dest][0]);
                check_count("single_flits", sent_edge[p] + 2, rx_edge[dest][0]);
            end
        end
        repeat (4) @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            check_count("single_flits", 1, cred_edge[p].size());
            if (cred_edge[p].size() > 0) begin
                check_count("single_flits", sent_edge[p] + 2, cred_edge[p][0]);
            end
        end
        finish_test("single_flits", errs);
    endtask

    task automatic test_wormhole();
        int    errs;
        bit    ok;
        flit_t pkt_a [$];
        flit_t pkt_b [$];
        flit_t exp   [$];
        errs = err_count;
        clear_monitors();
        send_packet(1, 2, 4, pkt_a);
        send_packet(3, 2, 4, pkt_b);
        exp = {pkt_a, pkt_b};   // rr pointer at 0, input 1 wins first
        wait_rx("wormhole", 2, 8, ok);
        repeat (4) @(negedge clk);
        check_count("wormhole", 8, rx_q[2].size());
        if (ok) begin
            for (int i = 0; i < 8; i++) begin
                check_flit("wormhole", exp[i], rx_q[2][i]);
            end
        end
        finish_test("wormhole", errs);
    endtask

    task automatic test_backpressure();
        int    errs;
        bit    ok;
        flit_t pkt [$];
        errs = err_count;
        clear_monitors();
        hold[0] = 1'b1;
        send_packet(4, 0, 6, pkt);
        repeat (30) @(negedge clk);
        check_count("backpressure", DEPTH, rx_q[0].size());   // stalls on zero credit
        hold[0] = 1'b0;
        wait_rx("backpressure", 0, 6, ok);
        repeat (4) @(negedge clk);
        check_count("backpressure", 6, rx_q[0].size());
        if (ok) begin
            for (int i = 0; i < 6; i++) begin
                check_flit("backpressure", pkt[i], rx_q[0][i]);
            end
        end
        finish_test("backpressure", errs);
    endtask

    task automatic test_credit_release();
        int errs;
        int drive;
        errs = err_count;
        clear_monitors();
        @(posedge clk);
        drive = cyc + 1;
        credit_release_en[3] <= 1'b1;
        @(posedge clk);
        credit_release_en[3] <= 1'b0;
        repeat (DEPTH + 6) @(negedge clk);
        check_count("credit_release", DEPTH, cred_edge[3].size());
        for (int i = 0; i < cred_edge[3].size() && i < DEPTH; i++) begin
            check_count("credit_release", drive + 1 + i, cred_edge[3][i]);
        end
        for (int p = 0; p < NP; p++) begin
            if (p != 3) begin
                check_count("credit_release", 0, cred_edge[p].size());
            end
        end
        finish_test("credit_release", errs);
    endtask

    initial begin
        rst_n             = 1'b0;
        credit_release_en = '0;
        for (int p = 0; p < NP; p++) begin
            chan_in[p] = '0;
            hold[p]    = 1'b0;
        end
        apply_reset();
        test_reset();
        test_single_flits();
        apply_reset();   // brings every rr pointer back to port 0
        test_wormhole();
        test_backpressure();
        test_credit_release();   // last, it leaves extra upstream credits
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count,
                 i_dut.i_switch_allocator.i_router_assertions.assert_fails);
        if (err_count == 0 && i_dut.i_switch_allocator.i_router_assertions.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
noc_router_pkg.sv
input_port.sv
switch_allocator.sv
crossbar.sv
credit_release_gen.sv
router_two_stage.sv
router_assertions.sv
tb_router.sv

// ==== Bender.yml ====
package:
  name: noc_router

sources:
  - noc_router_pkg.sv
  - input_port.sv
  - switch_allocator.sv
  - crossbar.sv
  - credit_release_gen.sv
  - router_two_stage.sv
  - target: simulation
    files:
      - router_assertions.sv
      - tb_router.sv
